/* filelist.f */
+incdir+src
src/line_draw_pkg.sv
src/display_timings.sv
src/draw_line.sv
src/line_sequencer.sv
src/fb_arbiter.sv
src/framebuffer.sv
src/line_top.sv
verif/tb_line_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the line renderer testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -Wno-fatal --top-module tb_line_top \
    -f filelist.f --Mdir build/obj \
    || { echo "verilator build error"; exit 1; }

./build/obj/Vtb_line_top > build/sim.log 2>&1 ; cat build/sim.log

grep -q "test failed" build/sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "test passed" build/sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

/* src/display_timings.sv */
// raster scan counters for the small display
// gives screen position, data enable, syncs and frame and line start pulses
`timescale 1ns/100ps
`default_nettype none
`include "line_draw_config.svh"

module display_timings (
    input  wire logic                  clk_pix,
    input  wire logic                  reset,
    output logic signed [`LD_CORDW-1:0] sx,     // horizontal position
    output logic signed [`LD_CORDW-1:0] sy,     // vertical position
    output logic                       de,     // active area
    output logic                       hsync,  // active high
    output logic                       vsync,  // active high
    output logic                       frame,  // first pixel of frame
    output logic                       line    // first pixel of each row
);

    // position counters, sx wraps every line
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == `LD_H_TOTAL - 1) begin
            sx <= '0;  // next line
            sy <= (sy == `LD_V_TOTAL - 1) ? '0 : sy + 1;  // wrap at frame end
        end else begin
            sx <= sx + 1;
        end
    end

    // decode from the counters
    always_comb begin
        de    = (sx < `LD_FB_W) && (sy < `LD_FB_H);  // active area = fb size
        hsync = (sx >= `LD_HS_START) && (sx < `LD_HS_END);
        vsync = (sy >= `LD_VS_START) && (sy < `LD_VS_END);
        frame = (sx == 0) && (sy == 0);
        line  = (sx == 0);
    end

endmodule

`default_nettype wire

/* src/draw_line.sv */
// Bresenham line stepper for any octant
// start latches the endpoints, one pixel per cycle with oe high, done pulses at the end
`timescale 1ns/100ps
`default_nettype none
`include "line_draw_config.svh"

module draw_line import line_draw_pkg::*; (
    input  wire logic                        clk_pix,
    input  wire logic                        reset,
    input  wire logic                        start,    // one-cycle strobe
    input  wire logic                        oe,       // pixel accepted this cycle
    input  wire logic signed [`LD_CORDW-1:0] x0,
    input  wire logic signed [`LD_CORDW-1:0] y0,
    input  wire logic signed [`LD_CORDW-1:0] x1,
    input  wire logic signed [`LD_CORDW-1:0] y1,
    output logic signed [`LD_CORDW-1:0]      x,        // current pixel
    output logic signed [`LD_CORDW-1:0]      y,
    output logic                             drawing,  // x and y valid
    output logic                             done      // last pixel accepted
);

    line_state_e state;
    logic signed [`LD_CORDW-1:0] xa, ya, xb, yb;  // latched endpoints
    logic signed [`LD_CORDW:0]   dx, dy;          // dy kept negative
    logic signed [`LD_CORDW:0]   dx_c, dy_c;      // deltas from latched points
    logic signed [`LD_CORDW+1:0] err, derr;       // error term and its step
    logic                        right, down;     // step directions
    logic                        movx, movy;

    always_comb begin
        dx_c = (xa < xb) ? xb - xa : xa - xb;  // |dx|
        dy_c = (ya < yb) ? ya - yb : yb - ya;  // -|dy|
        movx = (2 * err >= dy);
        movy = (2 * err <= dx);
        derr = '0;
        if (movx) derr = derr + dy;
        if (movy) derr = derr + dx;
    end

    always_ff @(posedge clk_pix) begin
        done <= 1'b0;
        if (reset) begin
            state   <= L_IDLE;
            drawing <= 1'b0;
        end else begin
            case (state)
                L_INIT: begin
                    dx      <= dx_c;
                    dy      <= dy_c;
                    err     <= dx_c + dy_c;
                    right   <= (xa < xb);
                    down    <= (ya < yb);
                    x       <= xa;  // first pixel is the start point
                    y       <= ya;
                    drawing <= 1'b1;
                    state   <= L_DRAW;
                end
                L_DRAW: begin
                    if (oe) begin  // hold x and y while stalled
                        if (x == xb && y == yb) begin
                            drawing <= 1'b0;
                            done    <= 1'b1;
                            state   <= L_IDLE;
                        end else begin
                            if (movx) x <= right ? x + 1 : x - 1;
                            if (movy) y <= down ? y + 1 : y - 1;
                            err <= err + derr;
                        end
                    end
                end
                default: begin  // L_IDLE
                    if (start) begin
                        xa    <= x0;
                        ya    <= y0;
                        xb    <= x1;
                        yb    <= y1;
                        state <= L_INIT;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/fb_arbiter.sv */
// shares the single framebuffer port between scanner and writer
// scanner always wins during de, a waiting write sees wr_busy and holds
`timescale 1ns/100ps
`default_nettype none
`include "line_draw_config.svh"

module fb_arbiter import line_draw_pkg::*; (
    input  wire logic                        rd_en,    // display de
    input  wire logic signed [`LD_CORDW-1:0] sx,
    input  wire logic signed [`LD_CORDW-1:0] sy,
    input  wire fb_wr_t                      wr,
    output logic                             wr_busy,  // write must wait
    output logic                             clip_ok,  // write coords in range
    output fb_req_t                          req
);

    fb_addr_t rd_addr, wr_addr;

    always_comb begin
        rd_addr = fb_addr_t'(sy * `LD_FB_W + sx);
        wr_addr = fb_addr_t'(wr.y * `LD_FB_W + wr.x);  // wraps if out of range
        clip_ok = (wr.x >= 0) && (wr.x < `LD_FB_W)
               && (wr.y >= 0) && (wr.y < `LD_FB_H);  // flags wrapped addresses

        wr_busy   = rd_en && wr.we;  // write pending during active video
        req.we    = wr.we && !rd_en;
        req.addr  = rd_en ? rd_addr : wr_addr;
        req.wdata = wr.cidx;
    end

endmodule

`default_nettype wire

/* src/framebuffer.sv */
// single-port colour index memory followed by a fixed palette
// read data reaches the colour outputs two clocks after the request
`timescale 1ns/100ps
`default_nettype none
`include "line_draw_config.svh"

module framebuffer import line_draw_pkg::*; (
    input  wire logic           clk_pix,
    input  wire fb_req_t        req,
    input  wire logic           clip_ok,  // write coords inside buffer
    output logic [`LD_CHANW-1:0] red,
    output logic [`LD_CHANW-1:0] green,
    output logic [`LD_CHANW-1:0] blue
);

    localparam int FB_DEPTH = `LD_FB_W * `LD_FB_H;

    logic [`LD_CIDXW-1:0] mem [FB_DEPTH];  // block ram, no reset
    logic [`LD_CIDXW-1:0] cidx_q;           // registered read

    // memory port
    always_ff @(posedge clk_pix) begin
        if (req.we && clip_ok) mem[req.addr] <= req.wdata;  // clipped writes dropped
        cidx_q <= mem[req.addr];
    end

    // palette stage
    always_ff @(posedge clk_pix) begin
        red   <= cidx_q;
        green <= ~cidx_q;
        blue  <= {cidx_q[1:0], cidx_q[3:2]};  // nibble halves swapped
    end

endmodule

`default_nettype wire

/* src/line_draw_config.svh */
// sizes and raster timing shared by the line renderer
// include wherever an LD_ define is needed
`ifndef LINE_DRAW_CONFIG_SVH
`define LINE_DRAW_CONFIG_SVH

`define LD_CORDW     16  // signed screen coordinate width
`define LD_FB_W      32  // framebuffer width in pixels
`define LD_FB_H      16  // framebuffer height in pixels
`define LD_CIDXW     4   // colour index width
`define LD_CHANW     4   // palette channel width

`define LD_H_TOTAL   40  // clocks per line, active area is LD_FB_W
`define LD_V_TOTAL   20  // lines per frame, active area is LD_FB_H
`define LD_HS_START  34  // hsync window inside horizontal blanking
`define LD_HS_END    37
`define LD_VS_START  17  // vsync window inside vertical blanking
`define LD_VS_END    18

`endif

/* src/line_draw_pkg.sv */
// types shared by the line renderer blocks
// modules take these through a wildcard import in their header
`default_nettype none
`include "line_draw_config.svh"

package line_draw_pkg;

    typedef logic [8:0] fb_addr_t;  // y * LD_FB_W + x

    typedef enum logic [1:0] {OP_CLEAR, OP_LINE} ld_op_e;

    typedef struct packed {
        ld_op_e                      op;
        logic signed [`LD_CORDW-1:0] x0;
        logic signed [`LD_CORDW-1:0] y0;
        logic signed [`LD_CORDW-1:0] x1;
        logic signed [`LD_CORDW-1:0] y1;
        logic [`LD_CIDXW-1:0]        cidx;  // fill colour for OP_CLEAR too
    } ld_cmd_t;

    typedef struct packed {
        logic                        we;
        logic signed [`LD_CORDW-1:0] x;  // may lie outside the buffer
        logic signed [`LD_CORDW-1:0] y;
        logic [`LD_CIDXW-1:0]        cidx;
    } fb_wr_t;

    typedef struct packed {
        logic                 we;
        fb_addr_t             addr;
        logic [`LD_CIDXW-1:0] wdata;
    } fb_req_t;

    typedef struct packed {
        logic                 de;
        logic                 hsync;
        logic                 vsync;
        logic [`LD_CHANW-1:0] red;
        logic [`LD_CHANW-1:0] green;
        logic [`LD_CHANW-1:0] blue;
    } pixel_t;

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT_FRAME, S_CLEAR, S_DRAW, S_DONE
    } seq_state_e;

    typedef enum logic [1:0] {L_IDLE, L_INIT, L_DRAW} line_state_e;

endpackage

`default_nettype wire

/* src/line_sequencer.sv */
// runs one command per request, starting at the next frame pulse
// clear sweeps the whole buffer, line hands the endpoints to draw_line
`timescale 1ns/100ps
`default_nettype none
`include "line_draw_config.svh"

module line_sequencer import line_draw_pkg::*; (
    input  wire logic    clk_pix,
    input  wire logic    reset,
    input  wire logic    cmd_start,  // ignored while busy
    input  wire ld_cmd_t cmd,
    input  wire logic    frame,      // start of frame from display timing
    input  wire logic    wr_busy,    // write stalled by the scanner
    output fb_wr_t       wr,
    output logic         busy,
    output logic         done
);

    seq_state_e state;
    ld_cmd_t    cmd_q;  // latched command
    logic signed [`LD_CORDW-1:0] clr_x, clr_y;    // clear sweep position
    logic signed [`LD_CORDW-1:0] line_x, line_y;  // drawer pixel
    logic draw_start, drawing, draw_done;

    draw_line draw_line_inst (
        .clk_pix,
        .reset,
        .start(draw_start),
        .oe(!wr_busy),  // advance only when the write goes through
        .x0(cmd_q.x0),
        .y0(cmd_q.y0),
        .x1(cmd_q.x1),
        .y1(cmd_q.y1),
        .x(line_x),
        .y(line_y),
        .drawing,
        .done(draw_done)
    );

    // write source select
    always_comb begin
        if (state == S_CLEAR) begin
            wr.we = 1'b1;
            wr.x  = clr_x;
            wr.y  = clr_y;
        end else begin
            wr.we = drawing;
            wr.x  = line_x;
            wr.y  = line_y;
        end
        wr.cidx = cmd_q.cidx;
    end

    always_ff @(posedge clk_pix) begin
        draw_start <= 1'b0;
        done       <= 1'b0;
        if (reset) begin
            state <= S_IDLE;
            busy  <= 1'b0;
        end else begin
            case (state)
                S_WAIT_FRAME: begin
                    if (frame) begin
                        clr_x <= '0;
                        clr_y <= '0;
                        if (cmd_q.op == OP_CLEAR) begin
                            state <= S_CLEAR;
                        end else begin
                            draw_start <= 1'b1;
                            state      <= S_DRAW;
                        end
                    end
                end
                S_CLEAR: begin
                    if (!wr_busy) begin  // step only once written
                        if (clr_x == `LD_FB_W - 1) begin
                            clr_x <= '0;
                            clr_y <= clr_y + 1;
                            if (clr_y == `LD_FB_H - 1) state <= S_DONE;
                        end else begin
                            clr_x <= clr_x + 1;
                        end
                    end
                end
                S_DRAW: if (draw_done) state <= S_DONE;
                S_DONE: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: begin  // S_IDLE
                    if (cmd_start) begin
                        cmd_q <= cmd;
                        busy  <= 1'b1;
                        state <= S_WAIT_FRAME;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/line_top.sv */
// line renderer top level
// commands enter as a strobe, pixels leave with syncs aligned to the read path
`timescale 1ns/100ps
`default_nettype none
`include "line_draw_config.svh"

module line_top import line_draw_pkg::*; (
    input  wire logic    clk_pix,
    input  wire logic    reset,
    input  wire logic    cmd_start,
    input  wire ld_cmd_t cmd,
    output logic         busy,
    output logic         done,
    output pixel_t       pix
);

    logic signed [`LD_CORDW-1:0] sx, sy;
    logic de, hsync, vsync, frame;
    fb_wr_t  wr;
    fb_req_t req;
    logic    wr_busy, clip_ok;
    logic [`LD_CHANW-1:0] fb_red, fb_green, fb_blue;
    logic [1:0] de_q, hsync_q, vsync_q;  // two-stage delay lines

    display_timings display_timings_inst (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .de,
        .hsync,
        .vsync,
        .frame,
        .line()
    );

    line_sequencer line_sequencer_inst (
        .clk_pix,
        .reset,
        .cmd_start,
        .cmd,
        .frame,
        .wr_busy,
        .wr,
        .busy,
        .done
    );

    fb_arbiter fb_arbiter_inst (
        .rd_en(de),
        .sx,
        .sy,
        .wr,
        .wr_busy,
        .clip_ok,
        .req
    );

    framebuffer framebuffer_inst (
        .clk_pix,
        .req,
        .clip_ok,
        .red(fb_red),
        .green(fb_green),
        .blue(fb_blue)
    );

    // match memory read plus palette latency
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            de_q    <= '0;
            hsync_q <= '0;
            vsync_q <= '0;
        end else begin
            de_q    <= {de_q[0], de};
            hsync_q <= {hsync_q[0], hsync};
            vsync_q <= {vsync_q[0], vsync};
        end
    end

    always_comb begin
        pix.de    = de_q[1];
        pix.hsync = hsync_q[1];
        pix.vsync = vsync_q[1];
        pix.red   = fb_red;
        pix.green = fb_green;
        pix.blue  = fb_blue;
    end

endmodule

`default_nettype wire

/* verif/tb_line_top.sv */
// testbench for the line renderer top level
// runs clear and line commands and checks captured frames against a model buffer
`timescale 1ns/100ps
`default_nettype none
`include "line_draw_config.svh"

module tb_line_top import line_draw_pkg::*; ();

    localparam int NPIX       = `LD_FB_W * `LD_FB_H;
    localparam int WAIT_LIMIT = 12 * `LD_H_TOTAL * `LD_V_TOTAL;  // about 12 frames

    logic    clk_pix;
    logic    reset;
    logic    cmd_start;
    ld_cmd_t cmd;
    logic    busy;
    logic    done;
    pixel_t  pix;

    logic [`LD_CIDXW-1:0] ref_fb [NPIX];  // expected colour indices
    logic [`LD_CIDXW-1:0] exp_cidx;
    logic [31:0] rng_state;
    logic        reset_q = 1'b0;
    logic        vs_q = 1'b0;
    logic        de_q = 1'b0;
    logic        vs_rise;
    logic        pending;   // accepted command not yet done
    logic        pix_ok;
    logic [8:0]  pix_idx;   // raster position of the next de pixel
    int          de_count;
    int          frame_no;
    int          cmp_frame = -1;  // frame under comparison, -1 for none
    int          h_pos;     // output column, -1 until the first de
    int          h_now;

    line_top dut (.clk_pix, .reset, .cmd_start, .cmd, .busy, .done, .pix);

    always #4 clk_pix = ~clk_pix;  // 8 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic int rand_below(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % n);
    endfunction

    // red = index, green = inverted index, blue = index halves swapped
    function automatic logic [11:0] palette(input logic [3:0] c);
        return {c, ~c, c[1:0], c[3:2]};
    endfunction

    // steep, leftward and upward flags as octant number 0..7
    function automatic int octant(input int x0, y0, x1, y1);
        int adx, ady;
        adx = (x1 > x0) ? x1 - x0 : x0 - x1;
        ady = (y1 > y0) ? y1 - y0 : y0 - y1;
        return ((ady > adx) ? 4 : 0) + ((x1 < x0) ? 2 : 0) + ((y1 < y0) ? 1 : 0);
    endfunction

    always_comb begin
        vs_rise  = pix.vsync && !vs_q;
        exp_cidx = ref_fb[pix_idx];
        pix_ok   = ({pix.red, pix.green, pix.blue} == palette(exp_cidx));
        h_now    = (pix.de && !de_q) ? 0 : h_pos;  // row start resyncs the column
    end

    // frame capture and command bookkeeping
    always @(posedge clk_pix) begin
        reset_q <= reset;
        vs_q    <= pix.vsync;
        de_q    <= pix.de;
        if (reset) begin
            pix_idx  <= '0;
            de_count <= 0;
            frame_no <= 0;
            pending  <= 1'b0;
            h_pos    <= -1;
        end else begin
            if (vs_rise) begin  // new frame starts after vsync
                pix_idx  <= '0;
                de_count <= 0;
                frame_no <= frame_no + 1;
            end else if (pix.de) begin
                pix_idx  <= pix_idx + 1'b1;
                de_count <= de_count + 1;
            end
            if (cmd_start && !busy) pending <= 1'b1;
            else if (done) pending <= 1'b0;
            if (h_now < 0) h_pos <= -1;
            else h_pos <= (h_now == `LD_H_TOTAL - 1) ? 0 : h_now + 1;
        end
    end

    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping on timeout");
    endtask

    a_reset_idle: assert property (@(posedge clk_pix)
        reset_q |-> !busy && !done && !pix.de && !pix.hsync && !pix.vsync)
        else report_error("busy, done, de or a sync set after reset");
    a_frame_size: assert property (@(posedge clk_pix) disable iff (reset)
        vs_rise |-> de_count == NPIX) else report_error("wrong de pixel count in frame");
    a_hsync: assert property (@(posedge clk_pix) disable iff (reset)
        h_now >= 0 |-> pix.hsync == (h_now >= `LD_HS_START && h_now < `LD_HS_END))
        else report_error("hsync outside its window");
    a_busy_level: assert property (@(posedge clk_pix) disable iff (reset)
        pending |-> busy || done) else report_error("busy dropped before done");
    a_idle_level: assert property (@(posedge clk_pix) disable iff (reset)
        !pending |-> !busy && !done) else report_error("busy or done without a command");
    a_pixel: assert property (@(posedge clk_pix) disable iff (reset)
        frame_no == cmp_frame && pix.de |-> pix_ok) else report_error("pixel colour mismatch");

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clk_pix);
            #1;
            n++;
        end
        if (!done) abort_run("timed out waiting for the done pulse");
    endtask

    task automatic wait_frame(input int target);
        int n;
        n = 0;
        while (frame_no < target && n < WAIT_LIMIT) begin
            @(posedge clk_pix);
            #1;
            n++;
        end
        if (frame_no < target) abort_run("timed out waiting for a frame");
    endtask

    task automatic send_cmd(input ld_cmd_t c);
        cmd       = c;
        cmd_start = 1'b1;  // one-cycle strobe
        @(posedge clk_pix);
        #1;
        cmd_start = 1'b0;
    endtask

    task automatic check_next_frame();
        cmp_frame = frame_no + 1;
        wait_frame(cmp_frame + 1);  // whole frame passes the pixel check
        cmp_frame = -1;
    endtask

    // reference Bresenham with its own clip rule
    task automatic model_line(input int x0, y0, x1, y1, input logic [3:0] c);
        int x, y, dx, dy, sx, sy, err, e2;
        x   = x0;
        y   = y0;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
        sx  = (x0 < x1) ? 1 : -1;
        sy  = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        for (int n = 0; n < 4096; n++) begin
            if (x >= 0 && x < `LD_FB_W && y >= 0 && y < `LD_FB_H)
                ref_fb[y * `LD_FB_W + x] = c;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endtask

    task automatic run_clear(input logic [3:0] c);
        ld_cmd_t cc;
        cc      = '0;
        cc.op   = OP_CLEAR;
        cc.cidx = c;
        send_cmd(cc);
        foreach (ref_fb[i]) ref_fb[i] = c;
        wait_done();
        check_next_frame();
    endtask

    task automatic run_line(input int x0, y0, x1, y1, input logic [3:0] c, input bit extra);
        ld_cmd_t lc;
        lc      = '0;
        lc.op   = OP_LINE;
        lc.x0   = 16'(x0);
        lc.y0   = 16'(y0);
        lc.x1   = 16'(x1);
        lc.y1   = 16'(y1);
        lc.cidx = c;
        send_cmd(lc);
        if (extra) begin  // strobe while busy, must not be drawn
            @(posedge clk_pix);
            #1;
            lc.x0   = 0;
            lc.y0   = 15;
            lc.x1   = 31;
            lc.y1   = 0;
            lc.cidx = c + 4'd1;
            send_cmd(lc);
        end
        model_line(x0, y0, x1, y1, c);
        wait_done();
        check_next_frame();
    endtask

    initial begin
        int lx0, ly0, lx1, ly1, tries;
        clk_pix   = 1'b0;
        reset     = 1'b1;
        cmd_start = 1'b0;
        cmd       = '0;
        rng_state = 32'h969f3e66;
        repeat (16) @(posedge clk_pix);
        #1;
        reset = 1'b0;
        wait_frame(2);  // idle frames, de count only
        run_clear(4'(rand_below(16)));
        for (int i = 0; i < 10; i++) begin  // steps through all eight octants
            tries = 0;
            do begin  // redraw endpoints until they fall in octant i mod 8
                lx0 = rand_below(`LD_FB_W);
                ly0 = rand_below(`LD_FB_H);
                lx1 = rand_below(`LD_FB_W);
                ly1 = rand_below(`LD_FB_H);
                tries++;
            end while (octant(lx0, ly0, lx1, ly1) != i % 8 && tries < 1000);
            run_line(lx0, ly0, lx1, ly1, 4'(rand_below(16)), 1'b0);
        end
        run_line(-6, 3, 40, 12, 4'hA, 1'b0);  // crosses both side edges
        run_line(5, -4, 20, 25, 4'h3, 1'b0);  // crosses top and bottom
        run_line(35, 2, -3, 9, 4'hC, 1'b0);
        run_line(3, 2, 28, 13, 4'h7, 1'b1);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
